//--- tb.f
+incdir+verification
logic/ccc_pkg.sv
logic/ccc_decoder.sv
logic/ccc_length_regs.sv
logic/ccc_response_queue.sv
logic/i3c_ccc_target.sv
verification/tb_i3c_ccc_target.sv

//--- Makefile
# Verilator flow for the I3C CCC target testbench

TOP := tb_i3c_ccc_target

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f tb.f --top-module $(TOP) -Mdir obj_dir -o sim

# The log decides pass or fail
run: compile
	./obj_dir/sim | tee sim.log
	grep -q "^Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- verification/tb_ccc_model.svh
// Testbench model with the LFSR source, reference lengths and typed compare tasks
`ifndef TB_CCC_MODEL_SVH
`define TB_CCC_MODEL_SVH

// 32-bit Fibonacci LFSR with taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// One LFSR step per bit taken
function automatic int unsigned rand_bits(inout logic [31:0] s, input int n);
  int unsigned r;
  int          i;
  r = 0;
  for (i = 0; i < n; i++) begin
    s = lfsr_step(s);
    r = {r[30:0], s[0]};
  end
  return r;
endfunction

// Stored value of a SET with small values raised to the minimum
function automatic logic [LEN_W-1:0] clamp_len(input logic [LEN_W-1:0] v);
  return (v < LEN_MIN) ? LEN_MIN : v;
endfunction

// Expected GET response with the high byte first
function automatic void push_expected(input get_sel_e sel);
  logic [LEN_W-1:0] v;
  v = (sel == GET_MRL) ? model_mrl : model_mwl;
  exp_q.push_back(v[LEN_W-1:8]);
  exp_q.push_back(v[7:0]);
endfunction

task automatic check_byte(input string name, input logic [7:0] act, input logic [7:0] exp);
  if (act !== exp) begin
    err_val++;
    $display("** Error at %0t: %s expected 0x%02h, got 0x%02h", $time, name, exp, act);
  end
endtask

task automatic check_len(input string name, input logic [LEN_W-1:0] act,
                         input logic [LEN_W-1:0] exp);
  if (act !== exp) begin
    err_val++;
    $display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
  end
endtask

task automatic check_flag(input string name, input logic act, input logic exp);
  if (act !== exp) begin
    err_val++;
    $display("** Error at %0t: %s expected %0b, got %0b", $time, name, exp, act);
  end
endtask

`endif

//--- verification/tb_i3c_ccc_target.sv
// Testbench for the I3C CCC target covering GET responses, lengths, reset actions and HDR mode
module tb_i3c_ccc_target;
  timeunit 1ns;
  timeprecision 100ps;
  import ccc_pkg::*;

  localparam int unsigned N_RAND = 60;
  localparam logic [31:0] SEED   = 32'hd610_5de3;

  logic             clk_i;
  logic             rst_ni;
  logic [7:0]       rx_byte_i;
  byte_kind_e       rx_kind_i;
  logic             rx_valid_i;
  logic             ccc_end_i;
  logic             hdr_exit_i;
  logic             rsp_credit_i = 1'b0;
  logic [7:0]       rsp_byte_o;
  logic             rsp_valid_o;
  logic             hdr_mode_o;
  logic [7:0]       rst_action_o;
  logic             rst_action_valid_o;
  logic [LEN_W-1:0] mwl_o;
  logic [LEN_W-1:0] mrl_o;

  // Reference state
  logic [LEN_W-1:0] model_mwl;
  logic [LEN_W-1:0] model_mrl;
  logic             model_hdr;
  logic [7:0]       exp_q[$];
  int               exp_rd = 0;
  logic [7:0]       exp_rst_byte;
  int unsigned      rst_issued;
  int unsigned      rst_checked = 0;
  logic             checking;

  logic [31:0]      stim_lfsr;
  logic [31:0]      cred_lfsr = SEED;
  int unsigned      err_val = 0;
  int unsigned      err_misc = 0;
  int unsigned      cmd_cnt;
  int unsigned      cycle_cnt;
  int unsigned      sent_cnt = 0;
  int unsigned      cred_ret = 0;
  int unsigned      cred_wait = 0;
  int unsigned      sel;

  `include "tb_ccc_model.svh"

  i3c_ccc_target dut (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .rx_byte_i          (rx_byte_i),
    .rx_kind_i          (rx_kind_i),
    .rx_valid_i         (rx_valid_i),
    .ccc_end_i          (ccc_end_i),
    .hdr_exit_i         (hdr_exit_i),
    .rsp_credit_i       (rsp_credit_i),
    .rsp_byte_o         (rsp_byte_o),
    .rsp_valid_o        (rsp_valid_o),
    .hdr_mode_o         (hdr_mode_o),
    .rst_action_o       (rst_action_o),
    .rst_action_valid_o (rst_action_valid_o),
    .mwl_o              (mwl_o),
    .mrl_o              (mrl_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // One byte, valid for one cycle; the DUT takes it at the second edge
  task automatic drive_byte(input logic [7:0] b, input byte_kind_e k);
    @(posedge clk_i);
    rx_byte_i  <= b;
    rx_kind_i  <= k;
    rx_valid_i <= 1'b1;
    @(posedge clk_i);
    rx_valid_i <= 1'b0;
  endtask

  task automatic end_ccc();
    @(posedge clk_i);
    ccc_end_i <= 1'b1;
    @(posedge clk_i);
    ccc_end_i <= 1'b0;
  endtask

  task automatic gap();
    repeat (rand_bits(stim_lfsr, 2)) @(posedge clk_i);
  endtask

  // nbytes of 1 cuts the SET short, 3 adds an ignored byte
  task automatic write_length(input logic mrl, input logic direct, input logic [LEN_W-1:0] v,
                              input int nbytes);
    logic [7:0] code;
    cmd_cnt++;
    code = mrl ? CCC_SETMRL_B : CCC_SETMWL_B;
    code[7] = direct;
    drive_byte(code, BYTE_CODE);
    gap();
    drive_byte(v[LEN_W-1:8], BYTE_DATA);
    if (nbytes >= 2) begin
      gap();
      drive_byte(v[7:0], BYTE_DATA);
      if (mrl) begin
        model_mrl = clamp_len(v);
      end else begin
        model_mwl = clamp_len(v);
      end
    end
    if (nbytes >= 3) begin
      drive_byte(8'(rand_bits(stim_lfsr, 8)), BYTE_DATA);
    end
    end_ccc();
  endtask

  task automatic read_length(input get_sel_e gsel);
    cmd_cnt++;
    // Keep room for a whole response in the FIFO
    while (exp_q.size() - exp_rd > 2) begin
      @(posedge clk_i);
    end
    push_expected(gsel);
    drive_byte((gsel == GET_MRL) ? CCC_GETMRL : CCC_GETMWL, BYTE_CODE);
    end_ccc();
  endtask

  task automatic reset_action(input logic direct, input logic [7:0] b);
    cmd_cnt++;
    drive_byte(direct ? CCC_RSTACT_D : CCC_RSTACT_B, BYTE_CODE);
    gap();
    drive_byte(b, BYTE_DEFINING);
    exp_rst_byte = b;
    rst_issued++;
    end_ccc();
  endtask

  // Any other code with a defining byte and data is expected to do nothing
  task automatic ignored_ccc(input logic [7:0] code);
    cmd_cnt++;
    drive_byte(code, BYTE_CODE);
    drive_byte(8'(rand_bits(stim_lfsr, 8)), BYTE_DEFINING);
    drive_byte(8'(rand_bits(stim_lfsr, 8)), BYTE_DATA);
    drive_byte(8'(rand_bits(stim_lfsr, 8)), BYTE_DATA);
    end_ccc();
  endtask

  task automatic hdr_round_trip();
    cmd_cnt++;
    drive_byte(CCC_ENTHDR0, BYTE_CODE);
    model_hdr = 1'b1;
    end_ccc();
    gap();
    @(posedge clk_i);
    hdr_exit_i <= 1'b1;
    @(posedge clk_i);
    hdr_exit_i <= 1'b0;
    model_hdr = 1'b0;
  endtask

  function automatic logic [7:0] unknown_code();
    logic [7:0] c;
    c = 8'(rand_bits(stim_lfsr, 8));
    // Flipping bit 6 moves every supported code off the list
    if (c inside {CCC_SETMWL_B, CCC_SETMRL_B, CCC_ENTHDR0, CCC_RSTACT_B, CCC_SETMWL_D,
                  CCC_SETMRL_D, CCC_GETMWL, CCC_GETMRL, CCC_RSTACT_D}) begin
      c = c ^ 8'h40;
    end
    return c;
  endfunction

  function automatic logic [LEN_W-1:0] pick_len();
    if (rand_bits(stim_lfsr, 1) != 0) begin
      return 16'(rand_bits(stim_lfsr, 4));
    end
    return 16'(rand_bits(stim_lfsr, 16));
  endfunction

  // Transmitter returning one credit per byte after a random delay
  always @(posedge clk_i) begin
    if (cred_wait != 0) begin
      cred_wait--;
      rsp_credit_i <= 1'b0;
    end else if (sent_cnt != cred_ret) begin
      rsp_credit_i <= 1'b1;
      cred_ret++;
      cred_wait = rand_bits(cred_lfsr, 3);
    end else begin
      rsp_credit_i <= 1'b0;
    end
  end

  // Checker sampling between edges
  always @(negedge clk_i) begin
    if (checking) begin
      check_len("mwl_o", mwl_o, model_mwl);
      check_len("mrl_o", mrl_o, model_mrl);
      check_flag("hdr_mode_o", hdr_mode_o, model_hdr);
      check_flag("rst_action_valid_o", rst_action_valid_o, rst_issued != rst_checked);
      if (rst_action_valid_o && (rst_issued != rst_checked)) begin
        check_byte("rst_action_o", rst_action_o, exp_rst_byte);
      end
      rst_checked = rst_issued;
      if (rsp_valid_o) begin
        if (exp_rd >= exp_q.size()) begin
          err_misc++;
          $display("Response byte 0x%02h arrived with no GET pending", rsp_byte_o);
        end else begin
          check_byte("rsp_byte_o", rsp_byte_o, exp_q[exp_rd]);
          exp_rd++;
        end
        sent_cnt++;
        if (sent_cnt > cred_ret + 32'(RSP_CREDITS)) begin
          err_misc++;
          $display("Response sent at %0t without a credit available", $time);
        end
      end
    end
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt <= 40 * cmd_cnt + 100) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("Run stopped after %0d cycles with %0d response bytes still pending",
             cycle_cnt, exp_q.size() - exp_rd);
    $display("Checks done: %0d value errors, %0d other errors", err_val, err_misc);
    $display("Testbench failed");
    $finish;
  end

  initial begin
    rst_ni     = 1'b0;
    rx_byte_i  = 8'h00;
    rx_kind_i  = BYTE_CODE;
    rx_valid_i = 1'b0;
    ccc_end_i  = 1'b0;
    hdr_exit_i = 1'b0;
    model_mwl  = MWL_RESET;
    model_mrl  = MRL_RESET;
    model_hdr  = 1'b0;
    rst_issued = 0;
    cmd_cnt    = 0;
    checking   = 1'b0;
    stim_lfsr  = SEED;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    checking = 1'b1;

    // Defaults, then SET in both forms with clamping and a short SET
    read_length(GET_MWL);
    read_length(GET_MRL);
    write_length(1'b0, 1'b0, 16'd3, 2);
    read_length(GET_MWL);
    write_length(1'b1, 1'b1, 16'h1234, 3);
    read_length(GET_MRL);
    write_length(1'b0, 1'b1, 16'h0040, 1);
    reset_action(1'b0, 8'h5a);
    reset_action(1'b1, 8'ha5);
    ignored_ccc(8'h7f);
    hdr_round_trip();
    // Back-to-back GETs against slow credits
    repeat (4) begin
      read_length(GET_MRL);
      read_length(GET_MWL);
    end

    repeat (N_RAND) begin
      sel = rand_bits(stim_lfsr, 3);
      case (sel)
        0, 1: write_length(sel == 1, rand_bits(stim_lfsr, 1) != 0, pick_len(),
                           2 + int'(rand_bits(stim_lfsr, 1)));
        2: read_length(GET_MWL);
        3: read_length(GET_MRL);
        4: reset_action(rand_bits(stim_lfsr, 1) != 0, 8'(rand_bits(stim_lfsr, 8)));
        5: hdr_round_trip();
        6: ignored_ccc(unknown_code());
        default: write_length(rand_bits(stim_lfsr, 1) != 0, rand_bits(stim_lfsr, 1) != 0,
                              pick_len(), 1);
      endcase
      gap();
    end

    while (exp_rd < exp_q.size()) begin
      @(posedge clk_i);
    end
    repeat (10) @(posedge clk_i);
    $display("Checks done: %0d value errors, %0d other errors", err_val, err_misc);
    if ((err_val == 0) && (err_misc == 0)) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- logic/i3c_ccc_target.sv
// I3C target CCC block joining the decoder, length registers and response queue
module i3c_ccc_target (
  input  logic                      clk_i,
  input  logic                      rst_ni,

  // Tagged bytes from the bus receiver
  input  logic [7:0]                rx_byte_i,
  input  ccc_pkg::byte_kind_e       rx_kind_i,
  input  logic                      rx_valid_i,
  input  logic                      ccc_end_i,

  input  logic                      hdr_exit_i,

  // Transmitter side
  input  logic                      rsp_credit_i,
  output logic [7:0]                rsp_byte_o,
  output logic                      rsp_valid_o,

  output logic                      hdr_mode_o,
  output logic [7:0]                rst_action_o,
  output logic                      rst_action_valid_o,

  output logic [ccc_pkg::LEN_W-1:0] mwl_o,
  output logic [ccc_pkg::LEN_W-1:0] mrl_o
);
  import ccc_pkg::*;

  logic     get_req;
  get_sel_e get_sel;

  ccc_decoder u_decoder (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .rx_byte_i          (rx_byte_i),
    .rx_kind_i          (rx_kind_i),
    .rx_valid_i         (rx_valid_i),
    .ccc_end_i          (ccc_end_i),
    .hdr_exit_i         (hdr_exit_i),
    .get_req_o          (get_req),
    .get_sel_o          (get_sel),
    .hdr_mode_o         (hdr_mode_o),
    .rst_action_o       (rst_action_o),
    .rst_action_valid_o (rst_action_valid_o)
  );

  ccc_length_regs u_length_regs (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .rx_byte_i  (rx_byte_i),
    .rx_kind_i  (rx_kind_i),
    .rx_valid_i (rx_valid_i),
    .ccc_end_i  (ccc_end_i),
    .mwl_o      (mwl_o),
    .mrl_o      (mrl_o)
  );

  // Reads the same lengths that leave the block
  ccc_response_queue u_response_queue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .get_req_i    (get_req),
    .get_sel_i    (get_sel),
    .mwl_i        (mwl_o),
    .mrl_i        (mrl_o),
    .rsp_credit_i (rsp_credit_i),
    .rsp_byte_o   (rsp_byte_o),
    .rsp_valid_o  (rsp_valid_o)
  );

endmodule

//--- logic/ccc_response_queue.sv
// GET response queue that buffers length bytes and sends them against transmitter credits
module ccc_response_queue (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      get_req_i,
  input  ccc_pkg::get_sel_e         get_sel_i,
  input  logic [ccc_pkg::LEN_W-1:0] mwl_i,
  input  logic [ccc_pkg::LEN_W-1:0] mrl_i,
  input  logic                      rsp_credit_i,
  output logic [7:0]                rsp_byte_o,
  output logic                      rsp_valid_o
);
  import ccc_pkg::*;

  logic [7:0]           mem_q [RSP_FIFO_DEPTH];
  logic [RSP_PTR_W-1:0] wr_ptr_q;
  logic [RSP_PTR_W-1:0] rd_ptr_q;
  logic [RSP_CNT_W-1:0] fifo_cnt_q;
  logic [CREDIT_W-1:0]  cred_q;
  logic [LEN_W-1:0]     sel_len;
  logic                 has_room;
  logic                 push;
  logic                 pop;
  logic                 rsp_vld_q;
  logic [7:0]           rsp_byte_q;

  assign sel_len = (get_sel_i == GET_MRL) ? mrl_i : mwl_i;

  // Room for a whole response judged before this cycle's pop
  assign has_room = fifo_cnt_q <= RSP_CNT_W'(RSP_FIFO_DEPTH - RSP_BYTES);
  assign push     = get_req_i && has_room;

  // Send the head whenever a credit is available
  assign pop = (fifo_cnt_q != '0) && (cred_q != '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      fifo_cnt_q <= '0;
      cred_q     <= RSP_CREDITS;
      rsp_vld_q  <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + RSP_PTR_W'(RSP_BYTES);
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + RSP_PTR_W'(1);
      end
      fifo_cnt_q <= fifo_cnt_q + (push ? RSP_CNT_W'(RSP_BYTES) : '0) - RSP_CNT_W'(pop);
      cred_q     <= cred_q + CREDIT_W'(rsp_credit_i) - CREDIT_W'(pop);
      rsp_vld_q  <= pop;
    end
  end

  // Storage and output byte
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q]                  <= sel_len[LEN_W-1:8];
      mem_q[wr_ptr_q + RSP_PTR_W'(1)] <= sel_len[7:0];
    end
    if (pop) begin
      rsp_byte_q <= mem_q[rd_ptr_q];
    end
  end

  assign rsp_byte_o  = rsp_byte_q;
  assign rsp_valid_o = rsp_vld_q;

  // Returned credits may not exceed the transmitter buffer
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_credit_i |-> (cred_q < RSP_CREDITS) || pop)
    else $error("credit counter overflow");

  // A dropped GET loses its response
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    get_req_i |-> has_room)
    else $error("GET request while response FIFO full");

endmodule

//--- logic/ccc_length_regs.sv
// Max write and max read length registers, loaded by SETMWL and SETMRL with clamping
module ccc_length_regs (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic [7:0]                rx_byte_i,
  input  ccc_pkg::byte_kind_e       rx_kind_i,
  input  logic                      rx_valid_i,
  input  logic                      ccc_end_i,
  output logic [ccc_pkg::LEN_W-1:0] mwl_o,
  output logic [ccc_pkg::LEN_W-1:0] mrl_o
);
  import ccc_pkg::*;

  logic             code_byte;
  logic             data_byte;
  logic             is_setmwl;
  logic             is_setmrl;
  logic             set_act_q;
  logic             set_mrl_q;
  logic [1:0]       data_cnt_q;
  logic [7:0]       hi_q;
  logic [LEN_W-1:0] set_val;
  logic [LEN_W-1:0] set_clamped;
  logic [LEN_W-1:0] mwl_q;
  logic [LEN_W-1:0] mrl_q;

  assign code_byte = rx_valid_i && (rx_kind_i == BYTE_CODE);
  assign data_byte = rx_valid_i && (rx_kind_i == BYTE_DATA) && set_act_q;
  assign is_setmwl = (rx_byte_i == CCC_SETMWL_B) || (rx_byte_i == CCC_SETMWL_D);
  assign is_setmrl = (rx_byte_i == CCC_SETMRL_B) || (rx_byte_i == CCC_SETMRL_D);

  // High byte arrives first
  assign set_val     = {hi_q, rx_byte_i};
  assign set_clamped = (set_val < LEN_MIN) ? LEN_MIN : set_val;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      set_act_q  <= 1'b0;
      set_mrl_q  <= 1'b0;
      data_cnt_q <= '0;
      mwl_q      <= MWL_RESET;
      mrl_q      <= MRL_RESET;
    end else begin
      // Second data byte completes the value
      if (data_byte && (data_cnt_q == 2'd1)) begin
        if (set_mrl_q) begin
          mrl_q <= set_clamped;
        end else begin
          mwl_q <= set_clamped;
        end
      end
      // Count saturates so extra bytes are ignored
      if (data_byte && (data_cnt_q != 2'd2)) begin
        data_cnt_q <= data_cnt_q + 2'd1;
      end
      if (ccc_end_i) begin
        set_act_q  <= 1'b0;
        data_cnt_q <= '0;
      end
      if (code_byte) begin
        set_act_q  <= is_setmwl || is_setmrl;
        set_mrl_q  <= is_setmrl;
        data_cnt_q <= '0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (data_byte && (data_cnt_q == 2'd0)) begin
      hi_q <= rx_byte_i;
    end
  end

  assign mwl_o = mwl_q;
  assign mrl_o = mrl_q;

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mwl_o >= LEN_MIN) && (mrl_o >= LEN_MIN))
    else $error("length register below LEN_MIN");

endmodule

//--- logic/ccc_decoder.sv
// CCC decoder that latches the command code and raises HDR, reset-action and GET requests
module ccc_decoder (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic [7:0]          rx_byte_i,
  input  ccc_pkg::byte_kind_e rx_kind_i,
  input  logic                rx_valid_i,
  input  logic                ccc_end_i,
  input  logic                hdr_exit_i,
  output logic                get_req_o,
  output ccc_pkg::get_sel_e   get_sel_o,
  output logic                hdr_mode_o,
  output logic [7:0]          rst_action_o,
  output logic                rst_action_valid_o
);
  import ccc_pkg::*;

  logic       code_byte;
  logic       def_byte;
  logic       is_get;
  logic       is_rstact;
  logic [7:0] code_q;
  logic       code_vld_q;
  logic       hdr_mode_q;
  logic       get_req_q;
  get_sel_e   get_sel_q;
  logic       rst_vld_q;
  logic [7:0] rst_action_q;

  assign code_byte = rx_valid_i && (rx_kind_i == BYTE_CODE);
  assign def_byte  = rx_valid_i && (rx_kind_i == BYTE_DEFINING);
  assign is_get    = (rx_byte_i == CCC_GETMWL) || (rx_byte_i == CCC_GETMRL);

  // RSTACT in either form looked up on the latched code
  assign is_rstact = code_vld_q && (code_q inside {CCC_RSTACT_B, CCC_RSTACT_D});

  // Code latch dropped at the end of the command
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      code_q     <= '0;
      code_vld_q <= 1'b0;
    end else begin
      if (ccc_end_i) begin
        code_vld_q <= 1'b0;
      end
      // A new code in the same cycle starts the next command
      if (code_byte) begin
        code_q     <= rx_byte_i;
        code_vld_q <= 1'b1;
      end
    end
  end

  // HDR flag and single-cycle request pulses
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hdr_mode_q <= 1'b0;
      get_req_q  <= 1'b0;
      rst_vld_q  <= 1'b0;
    end else begin
      if (hdr_exit_i) begin
        hdr_mode_q <= 1'b0;
      end
      if (code_byte && (rx_byte_i == CCC_ENTHDR0)) begin
        hdr_mode_q <= 1'b1;
      end
      get_req_q <= code_byte && is_get;
      rst_vld_q <= def_byte && is_rstact;
    end
  end

  // Payload for the pulses above
  always_ff @(posedge clk_i) begin
    if (code_byte && is_get) begin
      get_sel_q <= (rx_byte_i == CCC_GETMRL) ? GET_MRL : GET_MWL;
    end
    if (def_byte) begin
      rst_action_q <= rx_byte_i;
    end
  end

  assign get_req_o          = get_req_q;
  assign get_sel_o          = get_sel_q;
  assign hdr_mode_o         = hdr_mode_q;
  assign rst_action_o       = rst_action_q;
  assign rst_action_valid_o = rst_vld_q;

  // A GET needs a code byte and a reset action needs a defining byte
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(get_req_o && rst_action_valid_o))
    else $error("get_req_o and rst_action_valid_o pulsed together");

endmodule

//--- logic/ccc_pkg.sv
// CCC package with command codes, byte tags, length limits and response credit sizes
package ccc_pkg;

  // Supported common command codes
  // Bit 7 set marks the direct form of a CCC
  typedef enum logic [7:0] {
    CCC_SETMWL_B = 8'h09,
    CCC_SETMRL_B = 8'h0A,
    CCC_ENTHDR0  = 8'h20,
    CCC_RSTACT_B = 8'h2A,
    CCC_SETMWL_D = 8'h89,
    CCC_SETMRL_D = 8'h8A,
    CCC_GETMWL   = 8'h8B,
    CCC_GETMRL   = 8'h8C,
    CCC_RSTACT_D = 8'h9A
  } ccc_code_e;

  // Tag attached by the bus receiver to every byte
  typedef enum logic [1:0] {
    BYTE_CODE     = 2'd0,
    BYTE_DEFINING = 2'd1,
    BYTE_DATA     = 2'd2
  } byte_kind_e;

  // Which length register a GET reads
  typedef enum logic {
    GET_MWL = 1'b0,
    GET_MRL = 1'b1
  } get_sel_e;

  // Width of a max write / max read length value
  localparam int unsigned LEN_W = 16;

  // Values after reset
  localparam logic [LEN_W-1:0] MWL_RESET = 16'd256;
  localparam logic [LEN_W-1:0] MRL_RESET = 16'd256;

  // Smallest length a SET may leave in a register
  localparam logic [LEN_W-1:0] LEN_MIN = 16'd8;

  // Response FIFO holding two GET responses of two bytes each
  localparam int unsigned RSP_FIFO_DEPTH = 4;
  localparam int unsigned RSP_PTR_W      = $clog2(RSP_FIFO_DEPTH);

  // Occupancy counter needs one more bit than the pointers
  localparam int unsigned RSP_CNT_W = RSP_PTR_W + 1;

  // Bytes per GET response
  localparam int unsigned RSP_BYTES = 2;

  // Transmit credits
  localparam int unsigned CREDIT_W = 3;

  // Matches the transmitter buffer size
  localparam logic [CREDIT_W-1:0] RSP_CREDITS = 3'd2;

endpackage
